//--- arith_chk.sv
`default_nettype none
`timescale 1ns/1ns

module arith_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  busy,
    input logic                  done,
    input arith_data_pkg::word_t result
);

    // Number of failed assertions.
    int unsigned fail_count = 0;

    //////////////////////////////////////////////////
    // Handshake protocol.
    //////////////////////////////////////////////////

    done_one_cycle: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    ) else begin
        $error("done stayed high for more than one cycle");
        fail_count++;
    end

    done_in_busy: assert property (
        @(posedge clk) disable iff (rst) done |-> busy
    ) else begin
        $error("done high while busy is low");
        fail_count++;
    end

    // Reset leaves the unit idle.
    idle_after_reset: assert property (
        @(posedge clk) rst |=> !busy
    ) else begin
        $error("busy high in the cycle after reset");
        fail_count++;
    end

    result_held: assert property (
        @(posedge clk) disable iff (rst) !busy |=> $stable(result)
    ) else begin
        $error("result changed while idle");
        fail_count++;
    end

endmodule

bind arith_top arith_chk u_chk (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .done   (done),
    .result (result)
);

`default_nettype wire

//--- arith_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

`include "arith_params.svh"

module arith_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  arith_ctrl_pkg::op_e   op,
    input  arith_data_pkg::word_t mul_result,
    input  arith_data_pkg::word_t div_result,
    output logic                  mul_load,
    output logic                  mul_step,
    output logic                  div_load,
    output logic                  div_step,
    output logic                  div_signed,
    output logic                  busy,
    output logic                  done,
    output arith_data_pkg::word_t result
);

    // Step cycles per operation.
    localparam arith_data_pkg::count_t MUL_STEPS =
        arith_data_pkg::count_t'(`ARITH_WIDTH / `ARITH_MUL_BITS);
    localparam arith_data_pkg::count_t DIV_STEPS =
        arith_data_pkg::count_t'(`ARITH_WIDTH);

    arith_ctrl_pkg::state_e state;
    arith_ctrl_pkg::op_e    op_q;
    arith_data_pkg::count_t count;
    logic                   accept;
    logic                   stepping;
    logic                   run_mul;
    logic                   new_mul;

    //////////////////////////////////////////////////
    // Acceptance and engine strobes.
    //////////////////////////////////////////////////

    assign accept = (state == arith_ctrl_pkg::ST_IDLE) && start &&
                    (op != arith_ctrl_pkg::OP_NONE);

    assign new_mul = (op == arith_ctrl_pkg::OP_MUL);
    assign run_mul = (op_q == arith_ctrl_pkg::OP_MUL);

    // Steps run while the counter is nonzero.
    assign stepping = (state == arith_ctrl_pkg::ST_RUN) && (count != '0);

    assign mul_load = accept && new_mul;
    assign div_load = accept && !new_mul;
    assign mul_step = stepping && run_mul;
    assign div_step = stepping && !run_mul;

    // Live op at load time, captured op afterwards.
    assign div_signed = (state == arith_ctrl_pkg::ST_IDLE) ?
                        (op == arith_ctrl_pkg::OP_DIVS) :
                        (op_q == arith_ctrl_pkg::OP_DIVS);

    assign busy = (state != arith_ctrl_pkg::ST_IDLE);
    assign done = (state == arith_ctrl_pkg::ST_DONE);

    //////////////////////////////////////////////////
    // Sequencer.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= arith_ctrl_pkg::ST_IDLE;
            op_q   <= arith_ctrl_pkg::OP_NONE;
            count  <= '0;
            result <= '0;
        end else begin
            case (state)
                arith_ctrl_pkg::ST_IDLE: begin
                    if (accept) begin
                        state <= arith_ctrl_pkg::ST_RUN;
                        op_q  <= op;
                        count <= new_mul ? MUL_STEPS : DIV_STEPS;
                    end
                end
                arith_ctrl_pkg::ST_RUN: begin
                    if (count == '0) begin
                        // Engine finished on the previous edge.
                        result <= run_mul ? mul_result : div_result;
                        state  <= arith_ctrl_pkg::ST_DONE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                arith_ctrl_pkg::ST_DONE: begin
                    state <= arith_ctrl_pkg::ST_IDLE;
                end
                default: begin
                    state <= arith_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- arith_ctrl_pkg.sv
`default_nettype none

package arith_ctrl_pkg;

    // Operation select. OP_NONE is reserved and never accepted.
    typedef enum logic [1:0] {
        OP_MUL  = 2'd0,
        OP_DIVU = 2'd1,
        OP_DIVS = 2'd2,
        OP_NONE = 2'd3
    } op_e;

    // Sequencer states.
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } state_e;

endpackage

`default_nettype wire

//--- arith_data_pkg.sv
`default_nettype none

`include "arith_params.svh"

package arith_data_pkg;

    // One operand, quotient or result.
    typedef logic [`ARITH_WIDTH-1:0] word_t;

    // Partial remainder over quotient bits.
    typedef logic [2*`ARITH_WIDTH-1:0] dword_t;

    // Remaining step cycles.
    typedef logic [`ARITH_CNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

//--- arith_div.sv
`default_nettype none
`timescale 1ns/1ns

`include "arith_params.svh"

module arith_div (
    input  logic                  clk,
    input  arith_data_pkg::word_t a,
    input  arith_data_pkg::word_t b,
    input  logic                  signed_op,
    input  logic                  load,
    input  logic                  step,
    output arith_data_pkg::word_t quotient
);

    arith_data_pkg::word_t  a_mag;
    arith_data_pkg::word_t  b_mag;
    arith_data_pkg::word_t  divisor;
    arith_data_pkg::word_t  q_mag;
    arith_data_pkg::dword_t rem;
    logic [`ARITH_WIDTH+1:0] diff;
    logic                    borrow;
    logic                    a_neg;
    logic                    b_neg;
    logic                    neg_q;

    //////////////////////////////////////////////////
    // Sign pre-correction.
    //////////////////////////////////////////////////

    assign a_neg = signed_op && a[`ARITH_WIDTH-1];
    assign b_neg = signed_op && b[`ARITH_WIDTH-1];

    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    //////////////////////////////////////////////////
    // Trial subtraction.
    //////////////////////////////////////////////////

    // Shifted remainder needs one extra bit for large divisors.
    assign diff = {1'b0, rem[2*`ARITH_WIDTH-1:`ARITH_WIDTH-1]} -
                  {2'b00, divisor};

    assign borrow = diff[`ARITH_WIDTH+1];

    //////////////////////////////////////////////////
    // Restoring iteration.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            rem     <= {{`ARITH_WIDTH{1'b0}}, a_mag};
            divisor <= b_mag;
            neg_q   <= a_neg ^ b_neg;
        end else if (step) begin
            if (borrow) begin
                // Restore, quotient bit is 0.
                rem <= {rem[2*`ARITH_WIDTH-2:0], 1'b0};
            end else begin
                rem <= {diff[`ARITH_WIDTH-1:0], rem[`ARITH_WIDTH-2:0], 1'b1};
            end
        end
    end

    //////////////////////////////////////////////////
    // Sign post-correction.
    //////////////////////////////////////////////////

    assign q_mag = rem[`ARITH_WIDTH-1:0];

    // Truncates toward zero.
    assign quotient = neg_q ? -q_mag : q_mag;

endmodule

`default_nettype wire

//--- arith_mul.sv
`default_nettype none
`timescale 1ns/1ns

`include "arith_params.svh"

module arith_mul (
    input  logic                  clk,
    input  arith_data_pkg::word_t a,
    input  arith_data_pkg::word_t b,
    input  logic                  load,
    input  logic                  step,
    output arith_data_pkg::word_t product
);

    arith_data_pkg::word_t      mplier;
    arith_data_pkg::word_t      mcand;
    arith_data_pkg::word_t      acc;
    arith_data_pkg::word_t      partial;
    logic [`ARITH_MUL_BITS-1:0] digit;

    //////////////////////////////////////////////////
    // Partial product.
    //////////////////////////////////////////////////

    // Top group of multiplier bits, most significant first.
    assign digit = mplier[`ARITH_WIDTH-1 -: `ARITH_MUL_BITS];

    assign partial = mcand * arith_data_pkg::word_t'(digit);

    //////////////////////////////////////////////////
    // Shift and accumulate.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= b;
            mplier <= a;
            acc    <= '0;
        end else if (step) begin
            // Only the low word is kept.
            acc    <= (acc << `ARITH_MUL_BITS) + partial;
            mplier <= mplier << `ARITH_MUL_BITS;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

//--- arith_params.svh
`ifndef ARITH_PARAMS_SVH
`define ARITH_PARAMS_SVH

//////////////////////////////////////////////////
// Arithmetic unit sizing.
//////////////////////////////////////////////////

// Operand and result width.
`define ARITH_WIDTH 32

// Multiplier bits consumed per step.
// Must divide ARITH_WIDTH evenly.
`define ARITH_MUL_BITS 8

// Step counter width. Holds ARITH_WIDTH.
`define ARITH_CNT_WIDTH 6

`endif

//--- arith_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "arith_params.svh"

module arith_tb;

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_RANDOM      = 12;
    localparam int MUL_DONE_CYCLES = 5;
    localparam int DIV_DONE_CYCLES = 33;
    // Starts issued by all tests, plus two idle windows.
    localparam int NUM_OPS     = (6 + NUM_RANDOM) + (2 + NUM_RANDOM) + (5 + NUM_RANDOM) + 2 + 1 + 2;
    localparam int CYCLE_LIMIT = NUM_OPS * 40 + RESET_CYCLES + 200;

    logic                  clk;
    logic                  rst;
    logic                  start;
    arith_ctrl_pkg::op_e   op;
    arith_data_pkg::word_t a;
    arith_data_pkg::word_t b;
    logic                  busy;
    logic                  done;
    arith_data_pkg::word_t result;

    integer seed;
    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     issued = 0;
    int     completed = 0;

    // Pending operations, oldest first.
    arith_data_pkg::word_t res_q[$];
    arith_ctrl_pkg::op_e   kind_q[$];
    int                    lat_q[$];
    int                    start_q[$];

    arith_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model.
    //////////////////////////////////////////////////

    function automatic arith_data_pkg::word_t expected_result(
        input arith_ctrl_pkg::op_e   f_op,
        input arith_data_pkg::word_t x,
        input arith_data_pkg::word_t y
    );
        logic [2*`ARITH_WIDTH-1:0] prod;
        longint                    sx;
        longint                    sy;
        longint                    sq;
        prod = {{`ARITH_WIDTH{1'b0}}, x} * {{`ARITH_WIDTH{1'b0}}, y};
        sx = longint'($signed(x));
        sy = longint'($signed(y));
        case (f_op)
            arith_ctrl_pkg::OP_MUL: return prod[`ARITH_WIDTH-1:0];
            arith_ctrl_pkg::OP_DIVU: return (y == '0) ? '1 : x / y;
            arith_ctrl_pkg::OP_DIVS: begin
                // Longint division truncates toward zero.
                sq = sx / sy;
                return arith_data_pkg::word_t'(sq);
            end
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Compare and timeout.
    //////////////////////////////////////////////////

    always @(negedge clk) begin : compare
        arith_data_pkg::word_t want;
        arith_ctrl_pkg::op_e   want_op;
        int                    want_lat;
        int                    lat;
        if (!rst && done) begin
            if (res_q.size() == 0) begin
                $display("Error at %0t: done pulsed with no operation pending", $time);
                errors++;
            end else begin
                want     = res_q.pop_front();
                want_op  = kind_q.pop_front();
                want_lat = lat_q.pop_front();
                lat      = cycles - start_q.pop_front();
                checks++;
                if (result !== want) begin
                    $display("** Error at %0t: %s result %h, expected %h",
                             $time, want_op.name(), result, want);
                    errors++;
                end
                checks++;
                if (lat != want_lat) begin
                    $display("** Error at %0t: done %0d cycles after start, expected %0d",
                             $time, lat, want_lat);
                    errors++;
                end
                completed++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus tasks.
    //////////////////////////////////////////////////

    // Drives one start and records what the accepting edge should produce.
    task automatic issue_start(
        input arith_ctrl_pkg::op_e   t_op,
        input arith_data_pkg::word_t x,
        input arith_data_pkg::word_t y
    );
        @(negedge clk);
        while (busy) @(negedge clk);
        start = 1'b1;
        op    = t_op;
        a     = x;
        b     = y;
        @(negedge clk);
        res_q.push_back(expected_result(t_op, x, y));
        kind_q.push_back(t_op);
        lat_q.push_back(t_op == arith_ctrl_pkg::OP_MUL ? MUL_DONE_CYCLES : DIV_DONE_CYCLES);
        start_q.push_back(cycles);
        issued++;
        start = 1'b0;
    endtask

    task automatic run_op(
        input arith_ctrl_pkg::op_e   t_op,
        input arith_data_pkg::word_t x,
        input arith_data_pkg::word_t y
    );
        issue_start(t_op, x, y);
        wait (completed >= issued);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////

    initial begin : stimulus
        int                    errs;
        arith_data_pkg::word_t x;
        arith_data_pkg::word_t y;
        rst   = 1'b1;
        start = 1'b0;
        op    = arith_ctrl_pkg::OP_NONE;
        a     = '0;
        b     = '0;
        seed  = 32'hba610af6;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Idle outputs right after reset.
        errs = errors;
        repeat (8) begin
            @(negedge clk);
            checks++;
            if (busy !== 1'b0 || done !== 1'b0 || result !== '0) begin
                $display("** Error at %0t: busy %b done %b result %h after reset",
                         $time, busy, done, result);
                errors++;
            end
        end
        report_test("reset state", errs);

        // Reserved op code, also before any accepted start.
        errs = errors;
        start = 1'b1;
        op    = arith_ctrl_pkg::OP_NONE;
        a     = $random(seed);
        b     = $random(seed);
        @(negedge clk);
        start = 1'b0;
        repeat (40) begin
            @(negedge clk);
            checks++;
            if (busy !== 1'b0 || result !== '0) begin
                $display("** Error at %0t: reserved op started a run, busy %b result %h",
                         $time, busy, result);
                errors++;
            end
        end
        report_test("reserved op ignored", errs);

        errs = errors;
        run_op(arith_ctrl_pkg::OP_MUL, 32'd0, 32'h1234_5678);
        run_op(arith_ctrl_pkg::OP_MUL, 32'h8765_4321, 32'd0);
        run_op(arith_ctrl_pkg::OP_MUL, 32'd1, 32'hdead_beef);
        run_op(arith_ctrl_pkg::OP_MUL, 32'hcafe_f00d, 32'd1);
        run_op(arith_ctrl_pkg::OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
        run_op(arith_ctrl_pkg::OP_MUL, 32'hffff_ffff, 32'd2);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            x = $random(seed);
            y = $random(seed);
            if (i % 2 == 1) y = y >> 16;
            run_op(arith_ctrl_pkg::OP_MUL, x, y);
        end
        report_test("multiply", errs);

        errs = errors;
        run_op(arith_ctrl_pkg::OP_DIVU, 32'h0bad_cafe, 32'd0);
        run_op(arith_ctrl_pkg::OP_DIVU, 32'd0, 32'd0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            x = $random(seed);
            y = $random(seed);
            y = y >> ((i * 5) % 32);
            run_op(arith_ctrl_pkg::OP_DIVU, x, y);
        end
        report_test("unsigned divide", errs);

        errs = errors;
        run_op(arith_ctrl_pkg::OP_DIVS, 32'd100, 32'd7);
        run_op(arith_ctrl_pkg::OP_DIVS, -32'sd100, 32'd7);
        run_op(arith_ctrl_pkg::OP_DIVS, 32'd100, -32'sd7);
        run_op(arith_ctrl_pkg::OP_DIVS, -32'sd100, -32'sd7);
        run_op(arith_ctrl_pkg::OP_DIVS, 32'h8000_0000, 32'd2);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            x = $random(seed) & 32'h7fff_ffff;
            y = ($random(seed) & 32'h7fff_ffff) >> ((i * 3) % 30);
            if (y == '0) y = 32'd3;
            // Walk through the four sign combinations.
            if (i % 4 == 1 || i % 4 == 3) x = -x;
            if (i % 4 == 2 || i % 4 == 3) y = -y;
            run_op(arith_ctrl_pkg::OP_DIVS, x, y);
        end
        report_test("signed divide", errs);

        // Second request lands while the first divide runs.
        errs = errors;
        issue_start(arith_ctrl_pkg::OP_DIVU, 32'h0001_0000, 32'd16);
        start = 1'b1;
        op    = arith_ctrl_pkg::OP_MUL;
        a     = 32'd3;
        b     = 32'd5;
        repeat (3) begin
            @(negedge clk);
            checks++;
            if (busy !== 1'b1) begin
                $display("** Error at %0t: busy low during a running divide", $time);
                errors++;
            end
        end
        start = 1'b0;
        wait (completed >= issued);
        repeat (40) @(negedge clk);
        report_test("start while busy", errs);

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- arith_top.sv
`default_nettype none
`timescale 1ns/1ns

module arith_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  arith_ctrl_pkg::op_e   op,
    input  arith_data_pkg::word_t a,
    input  arith_data_pkg::word_t b,
    output logic                  busy,
    output logic                  done,
    output arith_data_pkg::word_t result
);

    logic                  mul_load;
    logic                  mul_step;
    logic                  div_load;
    logic                  div_step;
    logic                  div_signed;
    arith_data_pkg::word_t mul_result;
    arith_data_pkg::word_t div_result;

    //////////////////////////////////////////////////
    // Sequencer.
    //////////////////////////////////////////////////

    arith_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .mul_result (mul_result),
        .div_result (div_result),
        .mul_load   (mul_load),
        .mul_step   (mul_step),
        .div_load   (div_load),
        .div_step   (div_step),
        .div_signed (div_signed),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    //////////////////////////////////////////////////
    // Engines.
    //////////////////////////////////////////////////

    // Operands go straight to both engines.
    arith_mul u_mul (
        .clk     (clk),
        .a       (a),
        .b       (b),
        .load    (mul_load),
        .step    (mul_step),
        .product (mul_result)
    );

    arith_div u_div (
        .clk       (clk),
        .a         (a),
        .b         (b),
        .signed_op (div_signed),
        .load      (div_load),
        .step      (div_step),
        .quotient  (div_result)
    );

endmodule

`default_nettype wire

//--- build.f
+incdir+.
arith_data_pkg.sv
arith_ctrl_pkg.sv
arith_ctrl.sv
arith_mul.sv
arith_div.sv
arith_top.sv
arith_chk.sv
arith_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the arithmetic unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module arith_tb -f build.f -o arith_sim \
    || { echo "Build failed"; exit 1; }

out="$(./obj_dir/arith_sim +verilator+error+limit+1000 2>&1)"
echo "$out"

echo "$out" | grep -qx "Done: no errors" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
